/* verilog/dram_timing_pkg.sv */
`default_nettype none

package dram_timing_pkg;

    // width of the phase counter and the refresh counter
    localparam int CNT_W = 10;

    // terminal value of the phase counter
    localparam logic [CNT_W-1:0] CNT_ONE = 1;

    // ACT to READ/WRITE
    localparam logic [CNT_W-1:0] T_RCD = 4;

    // ACT to PRE, used when a refresh is already pending
    localparam logic [CNT_W-1:0] T_RAS = 8;

    // read and write latency from the column command
    localparam logic [CNT_W-1:0] T_RL = 5;
    localparam logic [CNT_W-1:0] T_WL = 4;

    // data burst length in clocks
    localparam logic [CNT_W-1:0] T_BURST = 4;

    // precharge time
    localparam logic [CNT_W-1:0] T_RP = 3;

    // refresh cycle time
    localparam logic [CNT_W-1:0] T_RFC = 12;

    // average refresh interval, kept short for simulation
    localparam logic [CNT_W-1:0] T_REFI = 200;

endpackage

`default_nettype wire

/* verilog/dram_cmd_pkg.sv */
`default_nettype none

package dram_cmd_pkg;

    localparam int BANK_W = 2;
    localparam int ROW_W  = 14;
    localparam int COL_W  = 10;

    // each command state lasts one cycle, the -ING state waits on the counter
    typedef enum logic [3:0] {
        IDLE,
        ACTIVATE,
        ACTIVATING,
        READ,
        READING,
        WRITE,
        WRITING,
        PRECHARGE,
        PRECHARGING,
        REFRESH,
        REFRESHING
    } cmd_state_e;

    // opcode on the command bus
    typedef enum logic [2:0] {
        NOP,
        ACT,
        RD,
        WR,
        PRE,
        REF
    } dram_op_e;

    typedef struct packed {
        logic              write;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } mem_req_t;

    // addr holds the row for ACT and the column for RD/WR
    typedef struct packed {
        dram_op_e          op;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  addr;
    } dram_cmd_t;

    typedef struct packed {
        logic act_done;
        logic rd_done;
        logic wr_done;
        logic pre_done;
        logic ref_done;
    } phase_done_t;

endpackage

`default_nettype wire

/* verilog/load_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module load_counter (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              load,
    input  logic [dram_timing_pkg::CNT_W-1:0] load_value,
    output logic [dram_timing_pkg::CNT_W-1:0] count,
    output logic                              count_done
);

    // counts down from the loaded value and parks at one
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end
        else if (load) begin
            count <= load_value;
        end
        else if (count > dram_timing_pkg::CNT_ONE) begin
            count <= count - dram_timing_pkg::CNT_ONE;
        end
    end

    // a load of L gives exactly L cycles down to and including the one
    assign count_done = (count == dram_timing_pkg::CNT_ONE);

endmodule

`default_nettype wire

/* verilog/timing_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module timing_ctrl (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        init_done,
    input  dram_cmd_pkg::cmd_state_e    state,
    output dram_cmd_pkg::phase_done_t   phase_done,
    output logic                        rf_req,
    output logic                        rd_en,
    output logic                        wr_en
);

    logic                              cnt_load;
    logic [dram_timing_pkg::CNT_W-1:0] cnt_load_value;
    logic [dram_timing_pkg::CNT_W-1:0] cnt_value;
    logic                              cnt_done;

    logic [dram_timing_pkg::CNT_W-1:0] refresh_count;
    logic [dram_timing_pkg::CNT_W-1:0] next_refresh_count;
    logic [dram_timing_pkg::CNT_W-1:0] refresh_limit;
    logic [dram_timing_pkg::CNT_W-1:0] next_refresh_limit;
    logic                              in_refresh;

    load_counter phase_counter (
        .CLK        (CLK),
        .nRST       (nRST),
        .load       (cnt_load),
        .load_value (cnt_load_value),
        .count      (cnt_value),
        .count_done (cnt_done)
    );

    // command states load the counter, -ING states watch it
    always_comb begin
        cnt_load       = 1'b0;
        cnt_load_value = '0;
        phase_done     = '0;
        rd_en          = 1'b0;
        wr_en          = 1'b0;

        case (state)
            dram_cmd_pkg::ACTIVATE: begin
                cnt_load = 1'b1;
                // keep the row open for tRAS when a refresh has to follow
                cnt_load_value = rf_req ? dram_timing_pkg::T_RAS : dram_timing_pkg::T_RCD;
            end
            dram_cmd_pkg::ACTIVATING: begin
                phase_done.act_done = cnt_done;
            end
            dram_cmd_pkg::READ: begin
                cnt_load       = 1'b1;
                cnt_load_value = dram_timing_pkg::T_RL + dram_timing_pkg::T_BURST;
            end
            dram_cmd_pkg::READING: begin
                // data window is the tail of the phase
                rd_en              = (cnt_value <= dram_timing_pkg::T_BURST);
                phase_done.rd_done = cnt_done;
            end
            dram_cmd_pkg::WRITE: begin
                cnt_load       = 1'b1;
                cnt_load_value = dram_timing_pkg::T_WL + dram_timing_pkg::T_BURST;
            end
            dram_cmd_pkg::WRITING: begin
                wr_en              = (cnt_value <= dram_timing_pkg::T_BURST);
                phase_done.wr_done = cnt_done;
            end
            dram_cmd_pkg::PRECHARGE: begin
                cnt_load       = 1'b1;
                cnt_load_value = dram_timing_pkg::T_RP;
            end
            dram_cmd_pkg::PRECHARGING: begin
                phase_done.pre_done = cnt_done;
            end
            dram_cmd_pkg::REFRESH: begin
                cnt_load       = 1'b1;
                cnt_load_value = dram_timing_pkg::T_RFC;
            end
            dram_cmd_pkg::REFRESHING: begin
                phase_done.ref_done = cnt_done;
            end
            default: begin
            end
        endcase
    end

    assign in_refresh = (state == dram_cmd_pkg::REFRESH) ||
                        (state == dram_cmd_pkg::REFRESHING);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refresh_count <= '0;
            refresh_limit <= dram_timing_pkg::T_REFI;
        end
        else begin
            refresh_count <= next_refresh_count;
            refresh_limit <= next_refresh_limit;
        end
    end

    always_comb begin
        // interval only runs once the device is initialized
        next_refresh_count = init_done ? refresh_count + 1'b1 : refresh_count;
        next_refresh_limit = refresh_limit;

        if (in_refresh) begin
            next_refresh_count = '0;
            // an on-time refresh restores the full interval
            if ((state == dram_cmd_pkg::REFRESH) &&
                (refresh_count <= dram_timing_pkg::T_REFI)) begin
                next_refresh_limit = dram_timing_pkg::T_REFI;
            end
        end
        else if (refresh_count > dram_timing_pkg::T_REFI) begin
            // a late refresh pulls the next one in by the same amount
            next_refresh_limit = dram_timing_pkg::T_REFI -
                                 (refresh_count - dram_timing_pkg::T_REFI);
        end
    end

    assign rf_req = (refresh_count >= refresh_limit) && (state != dram_cmd_pkg::REFRESH);

endmodule

`default_nettype wire

/* verilog/command_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module command_fsm (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        init_done,
    input  logic                        req_strobe,
    input  dram_cmd_pkg::mem_req_t      req,
    input  dram_cmd_pkg::phase_done_t   phase_done,
    input  logic                        rf_req,
    output dram_cmd_pkg::cmd_state_e    state,
    output dram_cmd_pkg::dram_cmd_t     cmd,
    output logic                        busy,
    output logic                        done
);

    dram_cmd_pkg::cmd_state_e next_state;
    dram_cmd_pkg::mem_req_t   req_q;
    logic                     ready;
    logic                     accept;

    // refresh wins over a new request in idle
    assign ready  = (state == dram_cmd_pkg::IDLE) && !rf_req && init_done;
    assign accept = ready && req_strobe;
    assign busy   = !ready;

    // only request sequences pass through precharge
    assign done = phase_done.pre_done;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dram_cmd_pkg::IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dram_cmd_pkg::IDLE: begin
                if (rf_req) begin
                    next_state = dram_cmd_pkg::REFRESH;
                end
                else if (accept) begin
                    next_state = dram_cmd_pkg::ACTIVATE;
                end
            end
            dram_cmd_pkg::ACTIVATE:    next_state = dram_cmd_pkg::ACTIVATING;
            dram_cmd_pkg::ACTIVATING: begin
                if (phase_done.act_done) begin
                    next_state = req_q.write ? dram_cmd_pkg::WRITE : dram_cmd_pkg::READ;
                end
            end
            dram_cmd_pkg::READ:        next_state = dram_cmd_pkg::READING;
            dram_cmd_pkg::READING: begin
                if (phase_done.rd_done) begin
                    next_state = dram_cmd_pkg::PRECHARGE;
                end
            end
            dram_cmd_pkg::WRITE:       next_state = dram_cmd_pkg::WRITING;
            dram_cmd_pkg::WRITING: begin
                if (phase_done.wr_done) begin
                    next_state = dram_cmd_pkg::PRECHARGE;
                end
            end
            dram_cmd_pkg::PRECHARGE:   next_state = dram_cmd_pkg::PRECHARGING;
            dram_cmd_pkg::PRECHARGING: begin
                if (phase_done.pre_done) begin
                    next_state = dram_cmd_pkg::IDLE;
                end
            end
            dram_cmd_pkg::REFRESH:     next_state = dram_cmd_pkg::REFRESHING;
            dram_cmd_pkg::REFRESHING: begin
                if (phase_done.ref_done) begin
                    next_state = dram_cmd_pkg::IDLE;
                end
            end
            default:                   next_state = dram_cmd_pkg::IDLE;
        endcase
    end

    // command bus carries an opcode only in the issue cycle
    always_comb begin
        cmd.op   = dram_cmd_pkg::NOP;
        cmd.bank = req_q.bank;
        cmd.addr = req_q.row;
        case (state)
            dram_cmd_pkg::ACTIVATE:  cmd.op = dram_cmd_pkg::ACT;
            dram_cmd_pkg::READ: begin
                cmd.op   = dram_cmd_pkg::RD;
                cmd.addr = {{(dram_cmd_pkg::ROW_W - dram_cmd_pkg::COL_W){1'b0}}, req_q.col};
            end
            dram_cmd_pkg::WRITE: begin
                cmd.op   = dram_cmd_pkg::WR;
                cmd.addr = {{(dram_cmd_pkg::ROW_W - dram_cmd_pkg::COL_W){1'b0}}, req_q.col};
            end
            dram_cmd_pkg::PRECHARGE: cmd.op = dram_cmd_pkg::PRE;
            dram_cmd_pkg::REFRESH:   cmd.op = dram_cmd_pkg::REF;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/dram_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    init_done,
    input  logic                    req_strobe,
    input  dram_cmd_pkg::mem_req_t  req,
    output dram_cmd_pkg::dram_cmd_t cmd,
    output logic                    rd_en,
    output logic                    wr_en,
    output logic                    busy,
    output logic                    done
);

    dram_cmd_pkg::cmd_state_e  state;
    dram_cmd_pkg::phase_done_t phase_done;
    logic                      rf_req;

    // sequencing of the closed-page command flow
    command_fsm command_fsm_inst (
        .CLK        (CLK),
        .nRST       (nRST),
        .init_done  (init_done),
        .req_strobe (req_strobe),
        .req        (req),
        .phase_done (phase_done),
        .rf_req     (rf_req),
        .state      (state),
        .cmd        (cmd),
        .busy       (busy),
        .done       (done)
    );

    // phase timing, data windows and refresh interval
    timing_ctrl timing_ctrl_inst (
        .CLK        (CLK),
        .nRST       (nRST),
        .init_done  (init_done),
        .state      (state),
        .phase_done (phase_done),
        .rf_req     (rf_req),
        .rd_en      (rd_en),
        .wr_en      (wr_en)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic nRST
);

    localparam time HALF_PERIOD = 4ns;
    localparam int  RESET_CYCLES = 4;

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // reset held low for the first few rising edges
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/dram_ctrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_properties (
    input wire logic                     CLK,
    input wire logic                     nRST,
    input wire logic                     init_done,
    input wire logic                     req_strobe,
    input wire logic                     busy,
    input wire logic                     done,
    input wire logic                     rd_en,
    input wire logic                     wr_en,
    input wire logic                     rf_req,
    input wire dram_cmd_pkg::dram_cmd_t  cmd,
    input wire dram_cmd_pkg::cmd_state_e state
);

    localparam int RCD     = int'(dram_timing_pkg::T_RCD);
    localparam int RAS     = int'(dram_timing_pkg::T_RAS);
    localparam int RP      = int'(dram_timing_pkg::T_RP);
    localparam int RFC     = int'(dram_timing_pkg::T_RFC);
    localparam int BURST   = int'(dram_timing_pkg::T_BURST);
    localparam int RD_LEN  = int'(dram_timing_pkg::T_RL) + BURST;
    localparam int WR_LEN  = int'(dram_timing_pkg::T_WL) + BURST;
    // longest request: ACT with tRAS, read phase, precharge, plus idle
    localparam int REQ_MAX = 1 + RAS + 1 + RD_LEN + 1 + RP + 2;
    localparam int REF_MAX = int'(dram_timing_pkg::T_REFI) + REQ_MAX;
    localparam int AGE_SAT = 1000;

    int fail_count = 0;
    int since_ref;
    int ref_age;

    // cycles since the last refresh ended
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            since_ref <= 0;
        end
        else if (state == dram_cmd_pkg::REFRESH || state == dram_cmd_pkg::REFRESHING) begin
            since_ref <= 0;
        end
        else if (init_done) begin
            since_ref <= since_ref + 1;
        end
    end

    // age of the last REF command, saturating
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ref_age <= AGE_SAT;
        end
        else begin
            ref_age <= (cmd.op == dram_cmd_pkg::REF) ? 1 :
                       (ref_age < AGE_SAT) ? ref_age + 1 : ref_age;
        end
    end

    a_accept_to_act: assert property (@(posedge CLK) disable iff (!nRST)
        (req_strobe && !busy) |=> (cmd.op == dram_cmd_pkg::ACT))
        else begin
            fail_count++;
            $error("accepted request did not issue ACT in the next cycle");
        end

    a_act_to_col: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd.op == dram_cmd_pkg::ACT && !rf_req) |->
            ##(1 + RCD) (cmd.op == dram_cmd_pkg::RD || cmd.op == dram_cmd_pkg::WR))
        else begin
            fail_count++;
            $error("column command not 1+tRCD after ACT");
        end

    a_rd_to_pre: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd.op == dram_cmd_pkg::RD) |-> ##(1 + RD_LEN) (cmd.op == dram_cmd_pkg::PRE))
        else begin
            fail_count++;
            $error("PRE not at expected distance after RD");
        end

    a_wr_to_pre: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd.op == dram_cmd_pkg::WR) |-> ##(1 + WR_LEN) (cmd.op == dram_cmd_pkg::PRE))
        else begin
            fail_count++;
            $error("PRE not at expected distance after WR");
        end

    a_pre_to_done: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd.op == dram_cmd_pkg::PRE) |-> ##RP done)
        else begin
            fail_count++;
            $error("done missing after precharge");
        end

    a_done_source: assert property (@(posedge CLK) disable iff (!nRST)
        done |-> $past(cmd.op == dram_cmd_pkg::PRE, RP))
        else begin
            fail_count++;
            $error("done without a preceding PRE");
        end

    // each data window is BURST cycles long and ends right before PRE
    a_rd_window: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(rd_en) |-> (cmd.op == dram_cmd_pkg::PRE) &&
            $past(rd_en, BURST) && !$past(rd_en, BURST + 1))
        else begin
            fail_count++;
            $error("read window has the wrong length");
        end

    a_wr_window: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(wr_en) |-> (cmd.op == dram_cmd_pkg::PRE) &&
            $past(wr_en, BURST) && !$past(wr_en, BURST + 1))
        else begin
            fail_count++;
            $error("write window has the wrong length");
        end

    a_busy_drop: assert property (@(posedge CLK) disable iff (!nRST)
        (req_strobe && busy) |=> (cmd.op != dram_cmd_pkg::ACT))
        else begin
            fail_count++;
            $error("strobe while busy issued an ACT");
        end

    a_ref_interval: assert property (@(posedge CLK) disable iff (!nRST)
        since_ref <= REF_MAX)
        else begin
            fail_count++;
            $error("refresh interval exceeded");
        end

    a_ref_to_act: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd.op == dram_cmd_pkg::ACT) |-> (ref_age > RFC))
        else begin
            fail_count++;
            $error("ACT issued inside tRFC");
        end

    // with a refresh pending the row stays open for tRAS before the column command
    a_ras: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd.op == dram_cmd_pkg::ACT && rf_req) |->
            ##(1 + RAS) (cmd.op == dram_cmd_pkg::RD || cmd.op == dram_cmd_pkg::WR))
        else begin
            fail_count++;
            $error("column command not 1+tRAS after ACT with refresh pending");
        end

    a_reset_quiet: assert property (@(posedge CLK)
        !nRST |-> (cmd.op == dram_cmd_pkg::NOP) && !rd_en && !wr_en && !done)
        else begin
            fail_count++;
            $error("outputs active during reset");
        end

endmodule

bind dram_ctrl_top dram_ctrl_properties props_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .init_done  (init_done),
    .req_strobe (req_strobe),
    .busy       (busy),
    .done       (done),
    .rd_en      (rd_en),
    .wr_en      (wr_en),
    .rf_req     (rf_req),
    .cmd        (cmd),
    .state      (state)
);

`default_nettype wire

/* tb/tb_dram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dram_ctrl;

    localparam int NUM_REQ   = 40;
    localparam int GAP_MAX   = 15;
    localparam int REQ_WORST = 1 + int'(dram_timing_pkg::T_RAS) + 1 +
                               int'(dram_timing_pkg::T_RL) + int'(dram_timing_pkg::T_BURST) +
                               1 + int'(dram_timing_pkg::T_RP) + 2;
    localparam int WATCHDOG_CYCLES = NUM_REQ * (REQ_WORST + GAP_MAX + 4) +
        4 * (int'(dram_timing_pkg::T_REFI) + int'(dram_timing_pkg::T_RFC));
    // REF cycle, tRFC, then idle cycles until the count is one short of tREFI
    localparam int REF_TO_DUE = int'(dram_timing_pkg::T_RFC) + int'(dram_timing_pkg::T_REFI);

    logic                    CLK;
    logic                    nRST;
    logic                    init_done;
    logic                    req_strobe;
    dram_cmd_pkg::mem_req_t  req;
    dram_cmd_pkg::dram_cmd_t cmd;
    logic                    rd_en;
    logic                    wr_en;
    logic                    busy;
    logic                    done;

    logic [31:0]             lfsr = 32'd79034;
    dram_cmd_pkg::mem_req_t  pending[$];
    int                      error_count = 0;
    int                      accepted = 0;
    int                      done_count = 0;

    tb_clock clock_gen (.CLK(CLK), .nRST(nRST));

    dram_ctrl_top dram_ctrl_top_inst (
        .CLK        (CLK),
        .nRST       (nRST),
        .init_done  (init_done),
        .req_strobe (req_strobe),
        .req        (req),
        .cmd        (cmd),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .busy       (busy),
        .done       (done)
    );

    // galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic random_request();
        logic [31:0] bits;
        take_bits(1, bits);
        req.write = bits[0];
        take_bits(2, bits);
        req.bank = bits[1:0];
        take_bits(14, bits);
        req.row = bits[13:0];
        take_bits(10, bits);
        req.col = bits[9:0];
    endtask

    // strobe in the last cycle before the refresh falls due,
    // so that the ACT sees the refresh pending
    task automatic request_before_refresh();
        while (cmd.op != dram_cmd_pkg::REF) next_cycle();
        repeat (REF_TO_DUE) next_cycle();
        random_request();
        req_strobe = 1'b1;
        next_cycle();
        req_strobe = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        error_count++;
        $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    endtask

    // scoreboard sampled mid-cycle where everything is settled
    always @(negedge CLK) begin
        if (nRST) begin
            if (req_strobe && !busy) begin
                pending.push_back(req);
                accepted++;
            end
            if (done) begin
                done_count++;
            end
            if (cmd.op == dram_cmd_pkg::ACT) begin
                if (pending.size() == 0) begin
                    error_count++;
                    $display("ACT issued with no accepted request");
                end
                else begin
                    if (cmd.bank != pending[0].bank)
                        report_mismatch("act_bank", pending[0].bank, cmd.bank);
                    if (cmd.addr != pending[0].row)
                        report_mismatch("act_row", pending[0].row, cmd.addr);
                end
            end
            if (cmd.op == dram_cmd_pkg::RD || cmd.op == dram_cmd_pkg::WR) begin
                if (pending.size() == 0) begin
                    error_count++;
                    $display("column command issued with no accepted request");
                end
                else begin
                    if ((cmd.op == dram_cmd_pkg::WR) != pending[0].write)
                        report_mismatch("col_write", pending[0].write, cmd.op == dram_cmd_pkg::WR);
                    if (cmd.bank != pending[0].bank)
                        report_mismatch("col_bank", pending[0].bank, cmd.bank);
                    if (cmd.addr != {4'b0, pending[0].col})
                        report_mismatch("col_addr", pending[0].col, cmd.addr);
                    void'(pending.pop_front());
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] bits;
        int assert_fails;
        init_done  = 1'b0;
        req_strobe = 1'b0;
        req        = '0;
        wait (nRST === 1'b1);
        repeat (5) next_cycle();
        init_done = 1'b1;

        for (int n = 0; n < NUM_REQ; n++) begin
            take_bits(4, bits);
            repeat (bits[3:0]) next_cycle();
            while (busy) next_cycle();
            random_request();
            req_strobe = 1'b1;
            next_cycle();
            // sometimes strobe again while the first request runs
            take_bits(1, bits);
            if (bits[0]) begin
                random_request();
                next_cycle();
            end
            req_strobe = 1'b0;
        end
        while (pending.size() > 0 || busy) next_cycle();

        request_before_refresh();
        while (pending.size() > 0 || busy) next_cycle();
        repeat (4) next_cycle();

        assert_fails = dram_ctrl_top_inst.props_inst.fail_count;
        if (done_count != accepted) begin
            error_count++;
            $display("%0d requests were accepted but %0d completed", accepted, done_count);
        end
        $display("errors: scoreboard %0d, assertions %0d", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end
        else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/dram_timing_pkg.sv
verilog/dram_cmd_pkg.sv
verilog/load_counter.sv
verilog/timing_ctrl.sv
verilog/command_fsm.sv
verilog/dram_ctrl_top.sv
tb/tb_clock.sv
tb/dram_ctrl_properties.sv
tb/tb_dram_ctrl.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dram_ctrl -f project.f
	-./obj_dir/Vtb_dram_ctrl +verilator+error+limit+100000 > $(LOG) 2>&1
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
